//--- rtl/video_pkg.sv
package video_pkg;

    // Pixels packed per group of three 32-bit words
    localparam int GROUP_PIXELS = 4;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // Raw video timing and data, sampled every cycle
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        rgb_t rgb;
    } video_in_t;

    typedef struct packed {
        logic sof;
        rgb_t rgb;
    } pixel_t;

endpackage

//--- rtl/udp_pkg.sv
package udp_pkg;

    localparam int UDP_WORD_W = 32;

    // One FIFO entry on the way to or from a UDP channel
    typedef struct packed {
        logic [UDP_WORD_W-1:0] data;
        logic                  last;
    } udp_beat_t;

    // Request/enable/data side of a channel
    // Ack travels on its own wire in the opposite direction
    typedef struct packed {
        logic                  request;
        logic                  enable;
        logic [UDP_WORD_W-1:0] data;
    } udp_send_t;

endpackage

//--- rtl/reset_counter.sv
`timescale 1ns/100ps
`default_nettype none

module reset_counter #(
    parameter int RESET_COUNT = 16
) (
    input  logic clk125m_i,
    input  logic reset_i,
    output logic rst_o
);

    localparam int CNT_W = $clog2(RESET_COUNT + 1);

    logic [CNT_W-1:0] count;

    // Reload while the external reset is held, then count down
    always_ff @(posedge clk125m_i) begin
        if (reset_i) begin
            count <= CNT_W'(RESET_COUNT);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign rst_o = reset_i || (count != '0);

endmodule // reset_counter

`default_nettype wire

//--- rtl/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter int  DEPTH     = 32,
    parameter type payload_t = logic [7:0]
) (
    input  logic                       clk125m_i,
    input  logic                       reset_i,
    input  logic                       wr_en_i,
    input  payload_t                   wr_data_i,
    input  logic                       rd_en_i,
    output payload_t                   rd_data_o,
    output logic                       empty_o,
    output logic                       full_o,
    output logic [$clog2(DEPTH+1)-1:0] free_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en_i && !full_o;
    assign do_rd = rd_en_i && !empty_o;

    always_ff @(posedge clk125m_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk125m_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is shown without a read request
    assign rd_data_o = mem[rd_ptr];
    assign empty_o   = (count == '0);
    assign full_o    = (count == CNT_W'(DEPTH));
    assign free_o    = CNT_W'(DEPTH) - count;

endmodule // sync_fifo

`default_nettype wire

//--- rtl/video_capture.sv
`timescale 1ns/100ps
`default_nettype none

module video_capture
    import video_pkg::*;
(
    input  logic      clk125m_i,
    input  logic      reset_i,
    input  video_in_t video_i,
    input  logic      fifo_full_i,
    output logic      pix_wr_o,
    output pixel_t    pix_o,
    output logic      overrun_o
);

    logic pix_valid;
    logic sof_pending;

    always_ff @(posedge clk125m_i) begin
        if (reset_i) begin
            pix_valid   <= 1'b0;
            sof_pending <= 1'b0;
            overrun_o   <= 1'b0;
        end else begin
            pix_valid <= video_i.de;
            // Armed by vsync and used up by the next pixel
            if (video_i.vsync) begin
                sof_pending <= 1'b1;
            end else if (video_i.de) begin
                sof_pending <= 1'b0;
            end
            if (pix_valid && fifo_full_i) begin
                overrun_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk125m_i) begin
        if (video_i.de) begin
            pix_o.rgb <= video_i.rgb;
            pix_o.sof <= sof_pending;
        end
    end

    // Video cannot stall so a pixel facing a full FIFO is dropped
    assign pix_wr_o = pix_valid && !fifo_full_i;

endmodule // video_capture

`default_nettype wire

//--- rtl/rgb_word_packer.sv
`timescale 1ns/100ps
`default_nettype none

module rgb_word_packer
    import video_pkg::*;
    import udp_pkg::*;
#(
    parameter int PACKET_WORDS = 6
) (
    input  logic      clk125m_i,
    input  logic      reset_i,
    input  pixel_t    pix_i,
    input  logic      pix_empty_i,
    output logic      pix_rd_o,
    input  logic      word_full_i,
    output logic      word_wr_o,
    output udp_beat_t word_o
);

    localparam int CNT_W = $clog2(PACKET_WORDS);

    logic [1:0]       phase;
    logic [1:0]       cur_phase;
    logic [23:0]      hold;
    logic [CNT_W-1:0] word_cnt;
    logic             take;

    assign take      = !pix_empty_i && !word_full_i;
    assign pix_rd_o  = take;
    // Start of frame always begins a new group
    assign cur_phase = pix_i.sof ? 2'd0 : phase;
    assign word_wr_o = take && (cur_phase != 2'd0);

    always_comb begin
        case (cur_phase)
            2'd1:    word_o.data = {hold, pix_i.rgb.red};
            2'd2:    word_o.data = {hold[15:0], pix_i.rgb.red, pix_i.rgb.green};
            default: word_o.data = {hold[7:0], pix_i.rgb};
        endcase
        word_o.last = (word_cnt == CNT_W'(PACKET_WORDS - 1));
    end

    // Leftover bytes wait here for the next word
    always_ff @(posedge clk125m_i) begin
        if (take) begin
            case (cur_phase)
                2'd0:    hold       <= pix_i.rgb;
                2'd1:    hold[15:0] <= {pix_i.rgb.green, pix_i.rgb.blue};
                2'd2:    hold[7:0]  <= pix_i.rgb.blue;
                default: hold       <= hold;
            endcase
        end
    end

    always_ff @(posedge clk125m_i) begin
        if (reset_i) begin
            phase    <= 2'd0;
            word_cnt <= '0;
        end else if (take) begin
            if (cur_phase == 2'(GROUP_PIXELS - 1)) begin
                phase <= 2'd0;
            end else begin
                phase <= cur_phase + 2'd1;
            end
            if (pix_i.sof) begin
                word_cnt <= '0;
            end else if (word_wr_o) begin
                word_cnt <= word_o.last ? '0 : word_cnt + 1'b1;
            end
        end
    end

endmodule // rgb_word_packer

`default_nettype wire

//--- rtl/udp_tx_sender.sv
`timescale 1ns/100ps
`default_nettype none

module udp_tx_sender
    import udp_pkg::*;
(
    input  logic      clk125m_i,
    input  logic      reset_i,
    input  udp_beat_t beat_i,
    input  logic      empty_i,
    output logic      rd_o,
    output udp_send_t send_o,
    input  logic      ack_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_stream
    } state_t;

    state_t state;
    logic   fire;

    // One word per cycle while ack is held and data is waiting
    assign fire = (state == st_stream) && ack_i && !empty_i;
    assign rd_o = fire;

    always_comb begin
        send_o.data    = beat_i.data;
        send_o.enable  = fire;
        // Drops together with the last word
        send_o.request = (state == st_request) ||
                         ((state == st_stream) && !(fire && beat_i.last));
    end

    always_ff @(posedge clk125m_i) begin
        if (reset_i) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (!empty_i) state <= st_request;
                end
                st_request: begin
                    if (ack_i) state <= st_stream;
                end
                st_stream: begin
                    if (fire && beat_i.last) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule // udp_tx_sender

`default_nettype wire

//--- rtl/udp_rx_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module udp_rx_receiver
    import udp_pkg::*;
#(
    parameter int MAX_RX_WORDS = 16,
    parameter int FIFO_DEPTH   = 32
) (
    input  logic                            clk125m_i,
    input  logic                            reset_i,
    input  udp_send_t                       recv_i,
    output logic                            ack_o,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] free_i,
    output logic                            wr_o,
    output udp_beat_t                       beat_o
);

    localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

    logic room;

    // Whole packet must fit before ack is given
    assign room = (free_i >= FREE_W'(MAX_RX_WORDS));

    always_ff @(posedge clk125m_i) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else if (ack_o) begin
            ack_o <= recv_i.request;
        end else begin
            ack_o <= recv_i.request && room;
        end
    end

    assign wr_o        = recv_i.enable && ack_o;
    assign beat_o.data = recv_i.data;
    // Final word arrives with request already low
    assign beat_o.last = !recv_i.request;

endmodule // udp_rx_receiver

`default_nettype wire

//--- rtl/video_udp_top.sv
`timescale 1ns/100ps
`default_nettype none

module video_udp_top
    import video_pkg::*;
    import udp_pkg::*;
#(
    parameter int RESET_COUNT   = 16,
    parameter int PACKET_WORDS  = 6,
    parameter int MAX_RX_WORDS  = 16,
    parameter int FIFO_DEPTH    = 32,
    parameter int HEARTBEAT_BIT = 4
) (
    input  logic       clk125m_i,
    input  logic       reset_i,
    input  video_in_t  video_i,
    output udp_send_t  udp0_send_o,
    input  logic       udp0_send_ack_i,
    input  udp_send_t  udp1_recv_i,
    output logic       udp1_recv_ack_o,
    output udp_send_t  udp1_send_o,
    input  logic       udp1_send_ack_i,
    output logic [2:0] led_o
);

    localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

    logic               rst;
    logic               overrun;
    logic [HEARTBEAT_BIT:0] hb_cnt;

    logic               pix_wr;
    pixel_t             pix_in;
    pixel_t             pix_head;
    logic               pix_full;
    logic               pix_empty;
    logic               pix_rd;

    logic               word_wr;
    udp_beat_t          word_in;
    udp_beat_t          word_head;
    logic               word_full;
    logic               word_empty;
    logic               word_rd;

    logic               loop_wr;
    udp_beat_t          loop_in;
    udp_beat_t          loop_head;
    logic               loop_empty;
    logic               loop_rd;
    logic [FREE_W-1:0]  loop_free;

    reset_counter #(.RESET_COUNT(RESET_COUNT)) u_reset_counter (
        .clk125m_i(clk125m_i), .reset_i(reset_i), .rst_o(rst)
    );

    always_ff @(posedge clk125m_i) begin
        if (rst) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    assign led_o = {hb_cnt[HEARTBEAT_BIT], ~rst, overrun};

    // Video to UDP channel 0
    video_capture u_video_capture (
        .clk125m_i(clk125m_i), .reset_i(rst), .video_i(video_i), .fifo_full_i(pix_full),
        .pix_wr_o(pix_wr), .pix_o(pix_in), .overrun_o(overrun)
    );

    sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(pixel_t)) u_pix_fifo (
        .clk125m_i(clk125m_i), .reset_i(rst), .wr_en_i(pix_wr), .wr_data_i(pix_in),
        .rd_en_i(pix_rd), .rd_data_o(pix_head), .empty_o(pix_empty), .full_o(pix_full),
        .free_o()
    );

    rgb_word_packer #(.PACKET_WORDS(PACKET_WORDS)) u_packer (
        .clk125m_i(clk125m_i), .reset_i(rst), .pix_i(pix_head), .pix_empty_i(pix_empty),
        .pix_rd_o(pix_rd), .word_full_i(word_full), .word_wr_o(word_wr), .word_o(word_in)
    );

    sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(udp_beat_t)) u_word_fifo (
        .clk125m_i(clk125m_i), .reset_i(rst), .wr_en_i(word_wr), .wr_data_i(word_in),
        .rd_en_i(word_rd), .rd_data_o(word_head), .empty_o(word_empty), .full_o(word_full),
        .free_o()
    );

    udp_tx_sender u_udp0_sender (
        .clk125m_i(clk125m_i), .reset_i(rst), .beat_i(word_head), .empty_i(word_empty),
        .rd_o(word_rd), .send_o(udp0_send_o), .ack_i(udp0_send_ack_i)
    );

    // Channel 1 loopback
    udp_rx_receiver #(.MAX_RX_WORDS(MAX_RX_WORDS), .FIFO_DEPTH(FIFO_DEPTH)) u_udp1_receiver (
        .clk125m_i(clk125m_i), .reset_i(rst), .recv_i(udp1_recv_i), .ack_o(udp1_recv_ack_o),
        .free_i(loop_free), .wr_o(loop_wr), .beat_o(loop_in)
    );

    sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(udp_beat_t)) u_loop_fifo (
        .clk125m_i(clk125m_i), .reset_i(rst), .wr_en_i(loop_wr), .wr_data_i(loop_in),
        .rd_en_i(loop_rd), .rd_data_o(loop_head), .empty_o(loop_empty), .full_o(),
        .free_o(loop_free)
    );

    udp_tx_sender u_udp1_sender (
        .clk125m_i(clk125m_i), .reset_i(rst), .beat_i(loop_head), .empty_i(loop_empty),
        .rd_o(loop_rd), .send_o(udp1_send_o), .ack_i(udp1_send_ack_i)
    );

endmodule // video_udp_top

`default_nettype wire

//--- verif/tb_checker.sv
`timescale 1ns/100ps

module tb_checker
    import video_pkg::*;
    import udp_pkg::*;
#(
    parameter int RESET_COUNT   = 16,
    parameter int PACKET_WORDS  = 6,
    parameter int FIFO_DEPTH    = 32,
    parameter int HEARTBEAT_BIT = 4
) (
    input  logic      clk_i,
    input  logic      reset_i,
    input  video_in_t video_i,
    input  udp_send_t udp0_send_i,
    input  logic      udp0_ack_i,
    input  udp_send_t udp1_recv_i,
    input  logic      udp1_recv_ack_i,
    input  udp_send_t udp1_send_i,
    input  logic      udp1_ack_i,
    input  logic [2:0] led_i,
    input  logic      ovr_phase_i,
    input  logic      done_i,
    output int        err_count_o
);

    // Pixels the DUT can buffer before the capture stage must drop one
    localparam int OVR_BOUND = FIFO_DEPTH + (FIFO_DEPTH * 4) / 3 + 5;

    string       names [6];
    int          checks [6];
    int          errs [6];
    int          total_errs = 0;
    int          rst_cnt = 0;
    bit          seen_reset = 0;
    bit          cur_rst;
    int          hb = 0;
    logic [7:0]  bytes [$];
    logic [32:0] exp0 [$];
    logic [32:0] exp1 [$];
    logic [32:0] e;
    int          word_idx = 0;
    bit          sof_pending = 0;
    int          pkt_len0 = 0;
    bit          end0_prev = 0;
    bit          req0_prev = 0;
    bit          ovr_started = 0;
    bit          led0_seen = 0;
    int          ovr_pixels = 0;

    assign err_count_o = total_errs;

    initial begin
        names[0] = "reset_quiet";
        names[1] = "pixel_packing";
        names[2] = "packet_framing";
        names[3] = "loopback";
        names[4] = "heartbeat";
        names[5] = "overrun";
    end

    task automatic value_error(input int t, input logic [39:0] expv, input logic [39:0] act);
        $display("** Error %s: expected %h, actual %h", names[t], expv, act);
        errs[t]++;
        total_errs++;
    endtask

    task automatic failure(input int t, input string msg);
        $display("%s failed: %s", names[t], msg);
        errs[t]++;
        total_errs++;
    endtask

    always @(negedge clk_i) begin
        cur_rst = reset_i || (rst_cnt != 0);
        if (reset_i) seen_reset = 1;
        if (seen_reset && cur_rst) begin
            checks[0]++;
            if ({udp0_send_i.request, udp0_send_i.enable, udp1_recv_ack_i,
                 udp1_send_i.request, udp1_send_i.enable, led_i} !== 8'h00) begin
                value_error(0, 40'h0, {udp0_send_i.request, udp0_send_i.enable,
                    udp1_recv_ack_i, udp1_send_i.request, udp1_send_i.enable, led_i});
            end
        end else if (seen_reset) begin
            checks[4]++;
            if (led_i[2:1] !== {hb[HEARTBEAT_BIT], 1'b1}) begin
                value_error(4, {hb[HEARTBEAT_BIT], 1'b1}, led_i[2:1]);
            end
            if (!ovr_phase_i) begin
                // Channel 0 data and framing
                if (udp0_send_i.enable) begin
                    checks[1]++;
                    checks[2]++;
                    if (!udp0_ack_i) failure(2, "channel 0 sent a word without ack");
                    if (exp0.size() == 0) begin
                        failure(1, "channel 0 sent a word that no pixels account for");
                    end else begin
                        e = exp0.pop_front();
                        pkt_len0++;
                        if (udp0_send_i.data !== e[31:0]) begin
                            value_error(1, e[31:0], udp0_send_i.data);
                        end
                        if (!udp0_send_i.request !== e[32]) begin
                            value_error(2, e[32], !udp0_send_i.request);
                        end
                        if (!udp0_send_i.request) begin
                            if (pkt_len0 != PACKET_WORDS) value_error(2, PACKET_WORDS, pkt_len0);
                            pkt_len0 = 0;
                        end
                    end
                end
                if (end0_prev && udp0_send_i.request) begin
                    failure(2, "request rose in the cycle right after a packet end");
                end
                if (req0_prev && !udp0_send_i.request && !udp0_send_i.enable) begin
                    failure(2, "request fell without a final word");
                end
                checks[5]++;
                if (led_i[0] !== 1'b0) value_error(5, 1'b0, led_i[0]);
            end else begin
                if (!ovr_started) begin
                    ovr_started = 1;
                    if (exp0.size() != 0) failure(2, "channel 0 words were never sent");
                    if (exp1.size() != 0) failure(3, "loopback words were never sent");
                end
                if (led_i[0]) led0_seen = 1;
                if (led0_seen || ovr_pixels > OVR_BOUND + 3) begin
                    checks[5]++;
                    if (led_i[0] !== 1'b1) value_error(5, 1'b1, led_i[0]);
                end
            end
            // Loopback words in order, with packet ends
            if (udp1_recv_i.enable && udp1_recv_ack_i) begin
                exp1.push_back({!udp1_recv_i.request, udp1_recv_i.data});
            end
            if (udp1_send_i.enable) begin
                checks[3]++;
                if (!udp1_ack_i) failure(3, "channel 1 sent a word without ack");
                if (exp1.size() == 0) begin
                    failure(3, "channel 1 sent a word that was never received");
                end else begin
                    e = exp1.pop_front();
                    if ({!udp1_send_i.request, udp1_send_i.data} !== e) begin
                        value_error(3, e, {!udp1_send_i.request, udp1_send_i.data});
                    end
                end
            end
        end
        end0_prev = udp0_send_i.enable && !udp0_send_i.request;
        req0_prev = udp0_send_i.request;

        // Model state for the coming edge
        if (!cur_rst && video_i.de && ovr_phase_i) ovr_pixels++;
        if (!cur_rst && !ovr_phase_i) begin
            if (video_i.vsync) begin
                sof_pending = 1;
            end else if (video_i.de) begin
                if (sof_pending) begin
                    bytes.delete();
                    word_idx = 0;
                    sof_pending = 0;
                end
                bytes.push_back(video_i.rgb.red);
                bytes.push_back(video_i.rgb.green);
                bytes.push_back(video_i.rgb.blue);
                while (bytes.size() >= 4) begin
                    e[31:0] = {bytes[0], bytes[1], bytes[2], bytes[3]};
                    e[32] = (word_idx == PACKET_WORDS - 1);
                    word_idx = e[32] ? 0 : word_idx + 1;
                    repeat (4) void'(bytes.pop_front());
                    exp0.push_back(e);
                end
            end
        end
        hb = cur_rst ? 0 : hb + 1;
        if (reset_i) begin
            rst_cnt = RESET_COUNT;
        end else if (rst_cnt > 0) begin
            rst_cnt--;
        end
    end

    always @(posedge done_i) begin
        if (!led0_seen) failure(5, "overrun flag never rose");
        for (int t = 0; t < 6; t++) begin
            $display("%-15s %s (%0d checks, %0d errors)", names[t],
                     (errs[t] == 0 && checks[t] > 0) ? "PASS" : "FAIL", checks[t], errs[t]);
            if (checks[t] == 0) total_errs++;
        end
        $display("tests: 6, checks: %0d, errors: %0d",
                 checks.sum(), total_errs);
    end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/100ps

module tb_top
    import video_pkg::*;
    import udp_pkg::*;
();

    localparam int RESET_COUNT   = 16;
    localparam int PACKET_WORDS  = 6;
    localparam int MAX_RX_WORDS  = 16;
    localparam int FIFO_DEPTH    = 32;
    localparam int HEARTBEAT_BIT = 4;
    localparam int FRAME_W       = 16;
    localparam int N_FRAMES      = 8;
    localparam int N_LOOP        = 12;
    localparam int OVR_PIXELS    = 160;
    localparam int STIM_CYCLES   = N_FRAMES * (1 + FRAME_W * 3) + N_LOOP * (16 * 4 + 3)
                                   + RESET_COUNT + 250 + OVR_PIXELS;

    logic        clk;
    logic        reset;
    video_in_t   video;
    udp_send_t   udp0_send;
    logic        udp0_ack;
    udp_send_t   udp1_recv;
    logic        udp1_recv_ack;
    udp_send_t   udp1_send;
    logic        udp1_ack;
    logic [2:0]  led;
    logic        ovr_phase;
    logic        hold_ack0;
    logic        done;
    int          err_count;
    logic [31:0] rng = 32'h21d1;

    video_udp_top #(
        .RESET_COUNT(RESET_COUNT), .PACKET_WORDS(PACKET_WORDS), .MAX_RX_WORDS(MAX_RX_WORDS),
        .FIFO_DEPTH(FIFO_DEPTH), .HEARTBEAT_BIT(HEARTBEAT_BIT)
    ) video_udp_top_inst (
        .clk125m_i(clk), .reset_i(reset), .video_i(video), .udp0_send_o(udp0_send),
        .udp0_send_ack_i(udp0_ack), .udp1_recv_i(udp1_recv), .udp1_recv_ack_o(udp1_recv_ack),
        .udp1_send_o(udp1_send), .udp1_send_ack_i(udp1_ack), .led_o(led)
    );

    tb_checker #(
        .RESET_COUNT(RESET_COUNT), .PACKET_WORDS(PACKET_WORDS), .FIFO_DEPTH(FIFO_DEPTH),
        .HEARTBEAT_BIT(HEARTBEAT_BIT)
    ) checker_inst (
        .clk_i(clk), .reset_i(reset), .video_i(video), .udp0_send_i(udp0_send),
        .udp0_ack_i(udp0_ack), .udp1_recv_i(udp1_recv), .udp1_recv_ack_i(udp1_recv_ack),
        .udp1_send_i(udp1_send), .udp1_ack_i(udp1_ack), .led_i(led),
        .ovr_phase_i(ovr_phase), .done_i(done), .err_count_o(err_count)
    );

    function logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic video_cycle(input logic vs, input logic de);
        logic [31:0] r;
        @(posedge clk);
        #1;
        video = '0;
        video.vsync = vs;
        video.de = de;
        if (de) begin
            r = next_random();
            video.rgb = r[23:0];
        end
    endtask

    task automatic send_frame();
        video_cycle(1'b1, 1'b0);
        for (int p = 0; p < FRAME_W; p++) begin
            repeat (next_random() % 3) video_cycle(1'b0, 1'b0);
            video_cycle(1'b0, 1'b1);
        end
        video_cycle(1'b0, 1'b0);
    endtask

    // Peer side of the channel 1 receive handshake
    task automatic send_loop_packet(input int len);
        int sent;
        sent = 0;
        @(posedge clk);
        #1;
        udp1_recv.request = 1'b1;
        udp1_recv.enable = 1'b0;
        while (sent < len) begin
            @(posedge clk);
            #1;
            if (udp1_recv_ack && (next_random() % 4 != 0)) begin
                udp1_recv.enable = 1'b1;
                udp1_recv.data = next_random();
                sent++;
                if (sent == len) udp1_recv.request = 1'b0;
            end else begin
                udp1_recv.enable = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        udp1_recv = '0;
        repeat (1 + next_random() % 3) @(posedge clk);
    endtask

    // Acks follow requests with random pauses
    initial begin
        forever begin
            @(posedge clk);
            #1;
            udp0_ack = udp0_send.request && !hold_ack0 && (next_random() % 4 != 0);
            udp1_ack = udp1_send.request && (next_random() % 4 != 0);
        end
    end

    initial begin
        #((STIM_CYCLES * 4 + 1000) * 100);
        $display("watchdog: the run did not finish in time");
        $display("sim failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        video = '0;
        udp1_recv = '0;
        udp0_ack = 1'b0;
        udp1_ack = 1'b0;
        ovr_phase = 1'b0;
        hold_ack0 = 1'b0;
        done = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        // Traffic during the stretched reset must be ignored
        udp1_recv.request = 1'b1;
        video.de = 1'b1;
        repeat (RESET_COUNT - 4) @(posedge clk);
        #1;
        udp1_recv = '0;
        video = '0;
        repeat (8) @(posedge clk);
        fork
            repeat (N_FRAMES) send_frame();
            repeat (N_LOOP) send_loop_packet(1 + next_random() % 16);
        join
        repeat (200) @(posedge clk);
        #1;
        ovr_phase = 1'b1;
        hold_ack0 = 1'b1;
        video_cycle(1'b1, 1'b0);
        repeat (OVR_PIXELS) video_cycle(1'b0, 1'b1);
        video_cycle(1'b0, 1'b0);
        repeat (20) @(posedge clk);
        done = 1'b1;
        #1;
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/video_pkg.sv
rtl/udp_pkg.sv
rtl/reset_counter.sv
rtl/sync_fifo.sv
rtl/video_capture.sv
rtl/rgb_word_packer.sv
rtl/udp_tx_sender.sv
rtl/udp_rx_receiver.sv
rtl/video_udp_top.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= tb.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q '^sim passed$$'

clean:
	rm -rf obj_dir
